// ==== Makefile ====
TOP := spi_flash_debug_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -f files.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== files.f ====
hdl/dbg_pkg.sv
hdl/flash_pkg.sv
hdl/spi_slave.sv
hdl/spi_flash_reader.sv
hdl/debug_cmd.sv
hdl/spi_flash_debug_top.sv
sim/qspi_flash_model.sv
sim/spi_flash_debug_tb.sv

// ==== hdl/dbg_pkg.sv ====
// debug command set, decoder states and fixed reply bytes for the SPI debug port
`default_nettype none

package dbg_pkg;

    // command bytes sent by the external SPI master
    typedef enum logic [7:0] {
        CMD_NOP   = 8'h00,
        CMD_READ  = 8'h01,
        CMD_LED   = 8'h02,
        CMD_ADDR0 = 8'h10,
        CMD_ADDR1 = 8'h11,
        CMD_ADDR2 = 8'h12,
        CMD_PING  = 8'hCC,
        CMD_ECHO  = 8'hCD
    } dbg_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,
        WAIT_FLASH,
        ECHO
    } dbg_state_e;

    // fixed replies
    localparam logic [7:0] REPLY_LED   = 8'hAB;
    localparam logic [7:0] REPLY_BUSY  = 8'hFE;
    localparam logic [7:0] REPLY_READY = 8'hFF;

endpackage

`default_nettype wire

// ==== hdl/debug_cmd.sv ====
// debug command decoder that answers SPI bytes and sequences flash reads
`timescale 1ns/10ps
`default_nettype none

module debug_cmd (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [7:0]                   recv_data,
    input  wire                          recv_ready,
    output logic [7:0]                   send_data,
    input  wire                          setup_done,
    input  wire                          busy,
    input  wire                          data_ready,
    input  wire  [7:0]                   flash_data,
    output logic [flash_pkg::ADDR_W-1:0] flash_addr,
    output logic                         do_read,
    output logic                         led
);

    dbg_pkg::dbg_state_e state;
    logic [1:0] addr_cnt;
    logic       issue_pending;
    logic       read_done;
    logic       ready_sent;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state         <= dbg_pkg::IDLE;
            send_data     <= 8'h00;
            flash_addr    <= '0;
            do_read       <= 1'b0;
            led           <= 1'b0;
            addr_cnt      <= 2'd0;
            issue_pending <= 1'b0;
            read_done     <= 1'b0;
            ready_sent    <= 1'b0;
        end else begin
            do_read <= 1'b0;
            // start the read once the flash is set up and free
            if (issue_pending && setup_done && !busy) begin
                do_read       <= 1'b1;
                issue_pending <= 1'b0;
            end
            if (data_ready) begin
                read_done <= 1'b1;
            end
            if (recv_ready) begin
                case (state)
                    dbg_pkg::IDLE: begin
                        case (dbg_pkg::dbg_cmd_e'(recv_data))
                            dbg_pkg::CMD_READ: begin
                                send_data <= 8'd3;
                                addr_cnt  <= 2'd3;
                                state     <= dbg_pkg::READ_ADDR;
                            end
                            dbg_pkg::CMD_LED: begin
                                led       <= !led;
                                send_data <= dbg_pkg::REPLY_LED;
                            end
                            dbg_pkg::CMD_ADDR0: send_data <= flash_addr[7:0];
                            dbg_pkg::CMD_ADDR1: send_data <= flash_addr[15:8];
                            dbg_pkg::CMD_ADDR2: send_data <= flash_addr[23:16];
                            dbg_pkg::CMD_PING:  send_data <= dbg_pkg::CMD_PING;
                            dbg_pkg::CMD_ECHO: begin
                                send_data <= dbg_pkg::CMD_ECHO;
                                state     <= dbg_pkg::ECHO;
                            end
                            default: send_data <= 8'h00;
                        endcase
                    end
                    dbg_pkg::READ_ADDR: begin
                        // address arrives msb first while the reply counts down
                        flash_addr <= {flash_addr[flash_pkg::ADDR_W-9:0], recv_data};
                        send_data  <= {6'b0, addr_cnt - 2'd1};
                        addr_cnt   <= addr_cnt - 2'd1;
                        if (addr_cnt == 2'd1) begin
                            issue_pending <= 1'b1;
                            read_done     <= 1'b0;
                            ready_sent    <= 1'b0;
                            state         <= dbg_pkg::WAIT_FLASH;
                        end
                    end
                    dbg_pkg::WAIT_FLASH: begin
                        if (!read_done) begin
                            send_data <= dbg_pkg::REPLY_BUSY;
                        end else if (!ready_sent) begin
                            send_data  <= dbg_pkg::REPLY_READY;
                            ready_sent <= 1'b1;
                        end else begin
                            send_data <= flash_data;
                            state     <= dbg_pkg::IDLE;
                        end
                    end
                    default: begin
                        send_data <= recv_data;
                        state     <= dbg_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    // the reader drops busy in the cycle it reports data
    busy_clear_on_data: assert property (@(posedge clk) disable iff (!rst)
        data_ready |-> !busy);

endmodule

`default_nettype wire

// ==== hdl/flash_pkg.sv ====
// serial NOR flash opcodes, reader states and address width
`default_nettype none

package flash_pkg;

    localparam int ADDR_W = 24;

    typedef enum logic [7:0] {
        OP_READ    = 8'h03,
        OP_RELEASE = 8'hAB
    } flash_op_e;

    // reader FSM with a one-time setup after reset
    typedef enum logic [2:0] {
        SETUP,
        SETUP_WAIT,
        IDLE,
        SHIFT,
        DONE
    } flash_state_e;

endpackage

`default_nettype wire

// ==== hdl/spi_flash_debug_top.sv ====
// debug bridge top linking the SPI slave port, command decoder and serial flash reader
`timescale 1ns/10ps
`default_nettype none

module spi_flash_debug_top #(
    parameter int SCLK_HALF = 1,
    parameter int RES_WAIT  = 16
) (
    input  wire clk,
    input  wire rst,
    input  wire sclk,
    input  wire mosi,
    input  wire ss,
    output wire miso,
    output wire flash_cs,
    output wire flash_sclk,
    output wire flash_si,
    input  wire flash_so,
    output wire flash_wp,
    output wire flash_hold,
    output wire led
);

    wire [7:0]                   send_data;
    wire [7:0]                   recv_data;
    wire                         recv_ready;
    wire [flash_pkg::ADDR_W-1:0] flash_addr;
    wire                         do_read;
    wire                         setup_done;
    wire                         busy;
    wire                         data_ready;
    wire [7:0]                   flash_data;

    spi_slave spi_slave_i (
        .clk        (clk),
        .rst        (rst),
        .sclk       (sclk),
        .mosi       (mosi),
        .ss         (ss),
        .miso       (miso),
        .send_data  (send_data),
        .recv_data  (recv_data),
        .recv_ready (recv_ready)
    );

    debug_cmd debug_cmd_i (
        .clk        (clk),
        .rst        (rst),
        .recv_data  (recv_data),
        .recv_ready (recv_ready),
        .send_data  (send_data),
        .setup_done (setup_done),
        .busy       (busy),
        .data_ready (data_ready),
        .flash_data (flash_data),
        .flash_addr (flash_addr),
        .do_read    (do_read),
        .led        (led)
    );

    spi_flash_reader #(
        .SCLK_HALF (SCLK_HALF),
        .RES_WAIT  (RES_WAIT)
    ) spi_flash_reader_i (
        .clk        (clk),
        .rst        (rst),
        .addr       (flash_addr),
        .do_read    (do_read),
        .setup_done (setup_done),
        .busy       (busy),
        .data_ready (data_ready),
        .data       (flash_data),
        .flash_cs   (flash_cs),
        .flash_sclk (flash_sclk),
        .flash_si   (flash_si),
        .flash_so   (flash_so),
        .flash_wp   (flash_wp),
        .flash_hold (flash_hold)
    );

endmodule

`default_nettype wire

// ==== hdl/spi_flash_reader.sv ====
// serial NOR flash reader with power-up release and single byte reads
`timescale 1ns/10ps
`default_nettype none

module spi_flash_reader #(
    parameter int SCLK_HALF = 1,
    parameter int RES_WAIT  = 16
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [flash_pkg::ADDR_W-1:0] addr,
    input  wire                        do_read,
    output logic                       setup_done,
    output logic                       busy,
    output logic                       data_ready,
    output logic [7:0]                 data,
    output logic                       flash_cs,
    output logic                       flash_sclk,
    output wire                        flash_si,
    input  wire                        flash_so,
    output wire                        flash_wp,
    output wire                        flash_hold
);

    localparam int DIV_W  = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
    localparam int WAIT_W = (RES_WAIT > 1) ? $clog2(RES_WAIT) : 1;
    localparam int SH_W   = 8 + flash_pkg::ADDR_W;

    flash_pkg::flash_state_e state;
    logic [DIV_W-1:0]  div_cnt;
    logic [WAIT_W-1:0] wait_cnt;
    logic [6:0]        tog_cnt;
    logic [SH_W-1:0]   sh_out;
    logic [7:0]        sh_in;
    logic              shifting;
    logic              tick;
    logic              last_tog;

    assign flash_wp   = 1'b1;
    assign flash_hold = 1'b1;
    assign flash_si   = sh_out[SH_W-1];

    assign shifting = !flash_cs && (state == flash_pkg::SETUP || state == flash_pkg::SHIFT);
    assign tick     = shifting && (div_cnt == DIV_W'(SCLK_HALF - 1));
    // release takes 8 sclk periods and a read takes 40
    assign last_tog = (tog_cnt == ((state == flash_pkg::SETUP) ? 7'd15 : 7'd79));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= flash_pkg::SETUP;
            setup_done <= 1'b0;
            busy       <= 1'b0;
            data_ready <= 1'b0;
            flash_cs   <= 1'b1;
            flash_sclk <= 1'b0;
            div_cnt    <= '0;
            wait_cnt   <= '0;
            tog_cnt    <= 7'd0;
            sh_out     <= '0;
        end else begin
            data_ready <= 1'b0;
            if (tick) begin
                div_cnt    <= '0;
                tog_cnt    <= tog_cnt + 7'd1;
                flash_sclk <= !flash_sclk;
                // si moves on the falling edge
                if (flash_sclk) begin
                    sh_out <= {sh_out[SH_W-2:0], 1'b0};
                end
            end else if (shifting) begin
                div_cnt <= div_cnt + DIV_W'(1);
            end
            case (state)
                flash_pkg::SETUP: begin
                    if (flash_cs) begin
                        sh_out   <= {flash_pkg::OP_RELEASE, {flash_pkg::ADDR_W{1'b0}}};
                        flash_cs <= 1'b0;
                        div_cnt  <= '0;
                        tog_cnt  <= 7'd0;
                    end else if (tick && last_tog) begin
                        flash_cs <= 1'b1;
                        wait_cnt <= '0;
                        state    <= flash_pkg::SETUP_WAIT;
                    end
                end
                flash_pkg::SETUP_WAIT: begin
                    wait_cnt <= wait_cnt + WAIT_W'(1);
                    if (wait_cnt == WAIT_W'(RES_WAIT - 1)) begin
                        setup_done <= 1'b1;
                        state      <= flash_pkg::IDLE;
                    end
                end
                flash_pkg::IDLE: begin
                    if (do_read) begin
                        sh_out   <= {flash_pkg::OP_READ, addr};
                        flash_cs <= 1'b0;
                        busy     <= 1'b1;
                        div_cnt  <= '0;
                        tog_cnt  <= 7'd0;
                        state    <= flash_pkg::SHIFT;
                    end
                end
                flash_pkg::SHIFT: begin
                    if (tick && last_tog) begin
                        state <= flash_pkg::DONE;
                    end
                end
                default: begin
                    flash_cs   <= 1'b1;
                    busy       <= 1'b0;
                    data_ready <= 1'b1;
                    state      <= flash_pkg::IDLE;
                end
            endcase
        end
    end

    // so is sampled on the rising edge and the last eight bits form the data byte
    always_ff @(posedge clk) begin
        if (tick && !flash_sclk) begin
            sh_in <= {sh_in[6:0], flash_so};
        end
        if (state == flash_pkg::DONE) begin
            data <= sh_in;
        end
    end

    read_not_busy: assert property (@(posedge clk) disable iff (!rst)
        do_read |-> !busy);

    cs_low_in_shift: assert property (@(posedge clk) disable iff (!rst)
        state == flash_pkg::SHIFT |-> !flash_cs);

endmodule

`default_nettype wire

// ==== hdl/spi_slave.sv ====
// mode 0 SPI slave that turns sclk bits into byte strobes in the clk domain
`timescale 1ns/10ps
`default_nettype none

module spi_slave (
    input  wire        clk,
    input  wire        rst,
    input  wire        sclk,
    input  wire        mosi,
    input  wire        ss,
    output wire        miso,
    input  wire  [7:0] send_data,
    output logic [7:0] recv_data,
    output logic       recv_ready
);

    // two flop synchronizers for the external pins
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] ss_sync;
    logic       sclk_d;
    logic       active;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    logic [7:0] tx_shift;

    assign active    = !ss_sync[1];
    assign sclk_rise = active && sclk_sync[1] && !sclk_d;
    assign sclk_fall = active && !sclk_sync[1] && sclk_d;
    assign miso      = tx_shift[7];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            ss_sync   <= 2'b11;
            sclk_d    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            ss_sync   <= {ss_sync[0], ss};
            sclk_d    <= sclk_sync[1];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bit_cnt    <= 3'd0;
            recv_ready <= 1'b0;
            tx_shift   <= 8'h00;
        end else begin
            recv_ready <= 1'b0;
            if (!active) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    recv_ready <= 1'b1;
                end
            end
            // first falling edge of a byte loads the reply and later ones shift it
            if (sclk_fall) begin
                if (bit_cnt == 3'd0) begin
                    tx_shift <= send_data;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                recv_data <= {rx_shift, mosi_sync[1]};
            end
        end
    end

    // one strobe per byte and never back to back
    recv_single: assert property (@(posedge clk) disable iff (!rst)
        recv_ready |=> !recv_ready);

endmodule

`default_nettype wire

// ==== sim/qspi_flash_model.sv ====
// behavioral serial NOR flash that answers release and single byte reads
`timescale 1ns/10ps
`default_nettype none

module qspi_flash_model (
    input  wire cs,
    input  wire sclk,
    input  wire si,
    output wire so
);

    logic [31:0] in_shift;
    logic [7:0]  read_byte;
    logic        awake = 1'b0;
    logic        so_q = 1'b0;
    int          bit_cnt = 0;
    wire  [31:0] next_shift;

    assign next_shift = {in_shift[30:0], si};
    assign so         = so_q;

    // si sampled on rising sclk while selected
    always @(posedge sclk or posedge cs) begin
        if (cs) begin
            // release only counts once the full opcode went in
            if (bit_cnt == 8 && in_shift[7:0] == flash_pkg::OP_RELEASE) begin
                awake <= 1'b1;
            end
            bit_cnt <= 0;
        end else begin
            in_shift <= next_shift;
            bit_cnt  <= bit_cnt + 1;
            if (bit_cnt == 31) begin
                if (awake && next_shift[31:24] == flash_pkg::OP_READ) begin
                    read_byte <= next_shift[23:16] ^ next_shift[15:8] ^ next_shift[7:0];
                end else begin
                    read_byte <= 8'h00;
                end
            end
        end
    end

    // data bits go out on falling sclk after the last address bit
    always @(negedge sclk) begin
        if (!cs && bit_cnt >= 32 && bit_cnt < 40) begin
            so_q <= read_byte[3'(39 - bit_cnt)];
        end
    end

endmodule

`default_nettype wire

// ==== sim/spi_flash_debug_tb.sv ====
// testbench for the SPI flash debug bridge with an SPI master driver and a flash model
`timescale 1ns/10ps
`default_nettype none

module spi_flash_debug_tb;

    logic clk;
    logic rst;
    logic sclk;
    logic mosi;
    logic ss;
    wire  miso;
    wire  flash_cs;
    wire  flash_sclk;
    wire  flash_si;
    wire  flash_so;
    wire  flash_wp;
    wire  flash_hold;
    wire  led;

    // expected and received bytes waiting for the compare process
    logic [7:0] got_q[$];
    logic [7:0] exp_q[$];
    string      what_q[$];
    int         rd_idx = 0;
    int         pass_count = 0;
    int         fail_count = 0;
    int         timeouts = 0;
    int         test_num = 0;
    int         test_start_fails = 0;

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    spi_flash_debug_top #(
        .SCLK_HALF (2),
        .RES_WAIT  (16)
    ) spi_flash_debug_top_i (
        .clk        (clk),
        .rst        (rst),
        .sclk       (sclk),
        .mosi       (mosi),
        .ss         (ss),
        .miso       (miso),
        .flash_cs   (flash_cs),
        .flash_sclk (flash_sclk),
        .flash_si   (flash_si),
        .flash_so   (flash_so),
        .flash_wp   (flash_wp),
        .flash_hold (flash_hold),
        .led        (led)
    );

    qspi_flash_model flash_i (
        .cs   (flash_cs),
        .sclk (flash_sclk),
        .si   (flash_si),
        .so   (flash_so)
    );

    // flash content is the xor of the three address bytes
    function automatic logic [7:0] ref_flash_byte(input logic [23:0] addr);
        return addr[23:16] ^ addr[15:8] ^ addr[7:0];
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got === exp) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("Mismatch at time %0t: %s, got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin
        while (rd_idx < got_q.size()) begin
            check_byte(got_q[rd_idx], exp_q[rd_idx], what_q[rd_idx]);
            rd_idx++;
        end
    end

    task automatic expect_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        got_q.push_back(got);
        exp_q.push_back(exp);
        what_q.push_back(what);
    endtask

    // mode 0 byte sent msb first with a half sclk period of 8 clk cycles
    task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
        logic [7:0] tx_sh;
        logic [7:0] rx_sh;
        tx_sh = tx;
        rx_sh = 8'h00;
        @(negedge clk);
        ss = 1'b0;
        repeat (8) begin
            mosi = tx_sh[7];
            tx_sh = {tx_sh[6:0], 1'b0};
            repeat (8) @(negedge clk);
            sclk = 1'b1;
            rx_sh = {rx_sh[6:0], miso};
            repeat (8) @(negedge clk);
            sclk = 1'b0;
        end
        repeat (8) @(negedge clk);
        ss = 1'b1;
        repeat (8) @(negedge clk);
        rx = rx_sh;
    endtask

    task automatic xfer_expect(input logic [7:0] tx, input logic [7:0] exp, input string what);
        logic [7:0] rx;
        spi_xfer(tx, rx);
        expect_byte(rx, exp, what);
    endtask

    task automatic read_and_check(input logic [23:0] addr);
        logic [7:0] rx;
        int polls;
        spi_xfer(dbg_pkg::CMD_READ, rx);
        xfer_expect(addr[23:16], 8'd3, "read count 3");
        xfer_expect(addr[15:8], 8'd2, "read count 2");
        xfer_expect(addr[7:0], 8'd1, "read count 1");
        xfer_expect(dbg_pkg::CMD_NOP, 8'd0, "read count 0");
        polls = 0;
        rx = dbg_pkg::REPLY_BUSY;
        while (rx == dbg_pkg::REPLY_BUSY && polls < 40) begin
            spi_xfer(dbg_pkg::CMD_NOP, rx);
            polls++;
        end
        if (rx == dbg_pkg::REPLY_BUSY) begin
            timeouts++;
            $display("Timeout at time %0t: flash read of %06h never finished", $time, addr);
        end else begin
            expect_byte(rx, dbg_pkg::REPLY_READY, "ready reply");
            xfer_expect(dbg_pkg::CMD_NOP, ref_flash_byte(addr), "flash data");
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        @(negedge clk);
        errs = fail_count + timeouts - test_start_fails;
        test_num++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errs);
        end
        test_start_fails = fail_count + timeouts;
    endtask

    initial begin
        logic [7:0]  rx;
        logic [7:0]  echo_byte;
        logic [23:0] addr;
        void'($urandom(32'h163e063f));
        rst = 1'b0;
        sclk = 1'b0;
        mosi = 1'b0;
        ss = 1'b1;
        repeat (8) @(negedge clk);
        expect_byte({4'b0, flash_cs, flash_sclk, led, miso}, 8'h08, "reset levels");
        rst = 1'b1;
        repeat (4) @(negedge clk);

        expect_byte({6'b0, flash_wp, flash_hold}, 8'h03, "wp and hold high");
        spi_xfer(dbg_pkg::CMD_PING, rx);
        xfer_expect(dbg_pkg::CMD_NOP, dbg_pkg::CMD_PING, "ping reply");
        xfer_expect(dbg_pkg::CMD_NOP, 8'h00, "nop reply");
        end_test("reset and ping");

        spi_xfer(dbg_pkg::CMD_LED, rx);
        xfer_expect(dbg_pkg::CMD_NOP, dbg_pkg::REPLY_LED, "led reply");
        expect_byte({7'b0, led}, 8'h01, "led on");
        spi_xfer(dbg_pkg::CMD_LED, rx);
        xfer_expect(dbg_pkg::CMD_NOP, dbg_pkg::REPLY_LED, "second led reply");
        expect_byte({7'b0, led}, 8'h00, "led off");
        end_test("led toggle");

        echo_byte = 8'($urandom());
        spi_xfer(dbg_pkg::CMD_ECHO, rx);
        xfer_expect(echo_byte, dbg_pkg::CMD_ECHO, "echo reply");
        xfer_expect(dbg_pkg::CMD_NOP, echo_byte, "echoed byte");
        end_test("echo");

        addr = 24'($urandom());
        read_and_check(addr);
        end_test("single read");

        spi_xfer(dbg_pkg::CMD_ADDR0, rx);
        xfer_expect(dbg_pkg::CMD_NOP, addr[7:0], "address byte 0");
        spi_xfer(dbg_pkg::CMD_ADDR1, rx);
        xfer_expect(dbg_pkg::CMD_NOP, addr[15:8], "address byte 1");
        spi_xfer(dbg_pkg::CMD_ADDR2, rx);
        xfer_expect(dbg_pkg::CMD_NOP, addr[23:16], "address byte 2");
        end_test("address readback");

        for (int k = 0; k < 4; k++) begin
            addr = 24'($urandom());
            read_and_check(addr);
        end
        end_test("back to back reads");

        @(negedge clk);
        $display("checks: %0d passed, %0d failed, %0d timeouts", pass_count, fail_count, timeouts);
        if (fail_count == 0 && timeouts == 0 && pass_count > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
